/* logic/la_pkg.sv */
package la_pkg;

    // global combine of the per-channel matches
    typedef enum logic [1:0] {
        mode_and  = 2'b00,
        mode_or   = 2'b01,
        mode_nand = 2'b10,
        mode_nor  = 2'b11
    } trig_mode_e;

    // per-channel value code, bits 2:0 of a condition
    typedef enum logic [2:0] {
        val_low  = 3'b000,
        val_high = 3'b001,
        val_any  = 3'b010,
        val_rise = 3'b011,
        val_fall = 3'b100,
        val_edge = 3'b101,
        val_hold = 3'b110
    } chan_value_e;

    // operator, bit 3 of a condition
    typedef enum logic {
        op_eq = 1'b0,
        op_ne = 1'b1
    } chan_op_e;

    localparam int cond_width = 4;
    localparam int data_width = 32;
    localparam int addr_width = 8;

    localparam logic [addr_width-1:0] addr_ctrl      = 8'h00;
    localparam logic [addr_width-1:0] addr_mode      = 8'h01;
    localparam logic [addr_width-1:0] addr_cond_base = 8'h10; // channel n at base + n

    localparam int ctrl_arm_bit   = 0;
    localparam int ctrl_force_bit = 8;  // write-only

    localparam logic [cond_width-1:0] cond_reset     = {op_eq, val_any};
    localparam logic [data_width-1:0] rdata_unmapped = '1;

endpackage

/* logic/la_cfg_regs.sv */
`timescale 1ns/1ps

module la_cfg_regs #(
    parameter int num_channels = 32
) (
    input  logic                                    clk,
    input  logic                                    analyzer_rstn_sync,
    input  logic                                    cfg_valid,
    input  logic                                    cfg_write,
    input  logic [la_pkg::addr_width-1:0]           cfg_addr,
    input  logic [la_pkg::data_width-1:0]           cfg_wdata,
    output logic                                    cfg_ready,
    output logic [la_pkg::data_width-1:0]           cfg_rdata,
    output logic                                    cfg_rvalid,
    input  logic                                    cfg_rready,
    input  logic                                    trig,
    output logic                                    arm,
    output logic                                    force_pulse,
    output la_pkg::trig_mode_e                      mode,
    output logic [num_channels*la_pkg::cond_width-1:0] cond_vec
);

    import la_pkg::*;

    logic                  wr_en;
    logic                  rd_en;
    logic                  ctrl_wr;
    logic [data_width-1:0] rdata_next;

    // one read in flight, so the port stalls while a response waits
    assign cfg_ready = ~cfg_rvalid;

    assign wr_en   = cfg_valid & cfg_ready & cfg_write;
    assign rd_en   = cfg_valid & cfg_ready & ~cfg_write;
    assign ctrl_wr = wr_en && (cfg_addr == addr_ctrl);

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            arm         <= 1'b0;
            force_pulse <= 1'b0;
            mode        <= mode_and;
            for (int i = 0; i < num_channels; i++) begin
                cond_vec[i*cond_width +: cond_width] <= cond_reset;
            end
        end else begin
            force_pulse <= ctrl_wr && cfg_wdata[ctrl_force_bit]; // single cycle

            if (ctrl_wr) begin
                arm <= cfg_wdata[ctrl_arm_bit];  // write wins over trig clear
            end else if (trig) begin
                arm <= 1'b0;
            end

            if (wr_en && (cfg_addr == addr_mode)) begin
                mode <= trig_mode_e'(cfg_wdata[1:0]);
            end

            for (int i = 0; i < num_channels; i++) begin
                if (wr_en && (cfg_addr == addr_cond_base + addr_width'(i))) begin
                    cond_vec[i*cond_width +: cond_width] <= cfg_wdata[cond_width-1:0];
                end
            end
        end
    end

    // read mux over the live register values
    always_comb begin
        rdata_next = rdata_unmapped;
        if (cfg_addr == addr_ctrl) begin
            rdata_next = '0;
            rdata_next[ctrl_arm_bit] = arm;  // force bit always reads 0
        end else if (cfg_addr == addr_mode) begin
            rdata_next = {{(data_width-2){1'b0}}, mode};
        end else begin
            for (int i = 0; i < num_channels; i++) begin
                if (cfg_addr == addr_cond_base + addr_width'(i)) begin
                    rdata_next = {{(data_width-cond_width){1'b0}},
                                  cond_vec[i*cond_width +: cond_width]};
                end
            end
        end
    end

    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            cfg_rvalid <= 1'b0;
        end else if (rd_en) begin
            cfg_rvalid <= 1'b1;
        end else if (cfg_rready) begin
            cfg_rvalid <= 1'b0;          // response taken
        end
    end

    // held until the master takes it
    always_ff @(posedge clk) begin
        if (rd_en) begin
            cfg_rdata <= rdata_next;
        end
    end

endmodule

/* logic/la_channel_match.sv */
`timescale 1ns/1ps

module la_channel_match #(
    parameter int num_channels = 32
) (
    input  logic                                       clk,
    input  logic                                       analyzer_rstn_sync,
    input  logic [num_channels-1:0]                    digital_in,
    input  logic [num_channels*la_pkg::cond_width-1:0] cond_vec,
    output logic [num_channels-1:0]                    match_vec
);

    import la_pkg::*;

    logic [num_channels-1:0] sample_cur;
    logic [num_channels-1:0] sample_prev;
    logic [num_channels-1:0] hit_vec;

    // current and previous sample, the pair feeds the edge codes
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            sample_cur  <= '0;
            sample_prev <= '0;
        end else begin
            sample_cur  <= digital_in;
            sample_prev <= sample_cur;
        end
    end

    for (genvar i = 0; i < num_channels; i++) begin : gen_chan
        chan_value_e value;
        chan_op_e    op;
        logic        raw;

        assign value = chan_value_e'(cond_vec[i*cond_width +: cond_width-1]);
        assign op    = chan_op_e'(cond_vec[i*cond_width + cond_width-1]);

        always_comb begin
            case (value)
                val_low:  raw = ~sample_cur[i];
                val_high: raw = sample_cur[i];
                val_any:  raw = 1'b1;
                val_rise: raw = ~sample_prev[i] & sample_cur[i];
                val_fall: raw = sample_prev[i] & ~sample_cur[i];
                val_edge: raw = sample_prev[i] ^ sample_cur[i];
                val_hold: raw = ~(sample_prev[i] ^ sample_cur[i]);
                default:  raw = 1'b0;  // code 7 has no meaning here
            endcase
        end

        assign hit_vec[i] = (op == op_ne) ? ~raw : raw;  // not-equal flips the match
    end

    // stage 1 result, one edge after the sample
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            match_vec <= '0;
        end else begin
            match_vec <= hit_vec;
        end
    end

endmodule

/* logic/la_trigger_combine.sv */
`timescale 1ns/1ps

module la_trigger_combine #(
    parameter int num_channels = 32
) (
    input  logic                    clk,
    input  logic                    analyzer_rstn_sync,
    input  logic [num_channels-1:0] match_vec,
    input  la_pkg::trig_mode_e      mode,
    input  logic                    arm,
    input  logic                    force_pulse,
    output logic                    trig
);

    import la_pkg::*;

    logic all_match;
    logic any_match;
    logic mode_hit;

    assign all_match = &match_vec;
    assign any_match = |match_vec;

    always_comb begin
        case (mode)
            mode_and:  mode_hit = all_match;
            mode_or:   mode_hit = any_match;
            mode_nand: mode_hit = ~all_match;
            mode_nor:  mode_hit = ~any_match;
        endcase
    end

    // arm is still set the cycle after a fire, so block a second pulse
    always_ff @(posedge clk or negedge analyzer_rstn_sync) begin
        if (!analyzer_rstn_sync) begin
            trig <= 1'b0;
        end else begin
            trig <= arm & ~trig & (force_pulse | mode_hit);
        end
    end

endmodule

/* logic/la_trigger_top.sv */
`timescale 1ns/1ps

module la_trigger_top #(
    parameter int num_channels = 32  // 1 to 32, cond addresses 0x10..0x2f
) (
    input  logic                          clk,
    input  logic                          analyzer_rstn_sync,
    input  logic [num_channels-1:0]       digital_in,
    input  logic                          cfg_valid,
    input  logic                          cfg_write,
    input  logic [la_pkg::addr_width-1:0] cfg_addr,
    input  logic [la_pkg::data_width-1:0] cfg_wdata,
    output logic                          cfg_ready,
    output logic [la_pkg::data_width-1:0] cfg_rdata,
    output logic                          cfg_rvalid,
    input  logic                          cfg_rready,
    output logic                          trig
);

    import la_pkg::*;

    logic                               arm;
    logic                               force_pulse;
    trig_mode_e                         mode;
    logic [num_channels*cond_width-1:0] cond_vec;
    logic [num_channels-1:0]            match_vec;

    la_cfg_regs #(.num_channels(num_channels)) i_cfg_regs (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .cfg_valid          (cfg_valid),
        .cfg_write          (cfg_write),
        .cfg_addr           (cfg_addr),
        .cfg_wdata          (cfg_wdata),
        .cfg_ready          (cfg_ready),
        .cfg_rdata          (cfg_rdata),
        .cfg_rvalid         (cfg_rvalid),
        .cfg_rready         (cfg_rready),
        .trig               (trig),
        .arm                (arm),
        .force_pulse        (force_pulse),
        .mode               (mode),
        .cond_vec           (cond_vec)
    );

    // stage 1, sample and per-channel match
    la_channel_match #(.num_channels(num_channels)) i_channel_match (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .digital_in         (digital_in),
        .cond_vec           (cond_vec),
        .match_vec          (match_vec)
    );

    // stage 2, global mode and trig pulse
    la_trigger_combine #(.num_channels(num_channels)) i_trigger_combine (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .match_vec          (match_vec),
        .mode               (mode),
        .arm                (arm),
        .force_pulse        (force_pulse),
        .trig               (trig)
    );

endmodule

/* verif/la_trigger_asserts.sv */
`timescale 1ns/1ps

module la_trigger_asserts (
    input logic                          clk,
    input logic                          analyzer_rstn_sync,
    input logic                          trig,
    input logic                          cfg_ready,
    input logic                          cfg_rvalid,
    input logic                          cfg_rready,
    input logic [la_pkg::data_width-1:0] cfg_rdata
);

    // a fire is a single-cycle pulse
    trig_single: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        trig |=> !trig)
        else $error("trig stayed high for two cycles");

    rdata_held: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        cfg_rvalid && !cfg_rready |=> cfg_rvalid && $stable(cfg_rdata))
        else $error("read response dropped or changed before it was taken");

    // only one read outstanding
    no_ready_with_rvalid: assert property (@(posedge clk) disable iff (!analyzer_rstn_sync)
        !(cfg_ready && cfg_rvalid))
        else $error("cfg_ready high while a read response waits");

endmodule

/* verif/la_tb.sv */
`timescale 1ns/1ps

module la_tb;

    import la_pkg::*;

    typedef struct packed {
        trig_mode_e  mode;
        logic [4:0]  chan;
        chan_value_e code;
        chan_op_e    op;
        logic        arm_on;
        logic        force_on;
        logic        lvl_prev;
        logic        lvl_cur;
        logic        exp_trig;
    } row_t;

    localparam int num_channels    = 32;
    localparam int num_rows        = 25;
    localparam int watchdog_cycles = num_rows * 40 + 200;

    logic                    clk;
    logic                    analyzer_rstn_sync;
    logic [num_channels-1:0] digital_in;
    logic                    cfg_valid;
    logic                    cfg_write;
    logic [addr_width-1:0]   cfg_addr;
    logic [data_width-1:0]   cfg_wdata;
    logic                    cfg_ready;
    logic [data_width-1:0]   cfg_rdata;
    logic                    cfg_rvalid;
    logic                    cfg_rready;
    logic                    trig;
    int                      errors;
    int                      checks;
    logic [15:0]             lfsr;
    logic [cond_width-1:0]   cond_model [num_channels];

    // mode, channel, code, op, arm, force, prev, cur, expected trig
    row_t rows [num_rows] = '{
        '{mode_and,  5'd3,  val_low,  op_eq, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1},
        '{mode_and,  5'd3,  val_low,  op_eq, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{mode_and,  5'd5,  val_high, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1},
        '{mode_and,  5'd5,  val_high, op_eq, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0},
        '{mode_and,  5'd7,  val_any,  op_eq, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1},
        '{mode_and,  5'd9,  val_rise, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1},
        '{mode_and,  5'd9,  val_rise, op_eq, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0},
        '{mode_and,  5'd11, val_fall, op_eq, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1},
        '{mode_and,  5'd11, val_fall, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{mode_and,  5'd13, val_edge, op_eq, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1},
        '{mode_and,  5'd13, val_edge, op_eq, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{mode_and,  5'd15, val_hold, op_eq, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
        '{mode_and,  5'd15, val_hold, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{mode_and,  5'd17, val_high, op_ne, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{mode_and,  5'd17, val_rise, op_ne, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
        '{mode_and,  5'd20, val_any,  op_eq, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{mode_nand, 5'd22, val_high, op_eq, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1},
        '{mode_nand, 5'd22, val_high, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{mode_and,  5'd24, val_low,  op_eq, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{mode_or,   5'd25, val_rise, op_eq, 1'b1, 1'b0, 1'b0, 1'b1, 1'b1},
        '{mode_or,   5'd25, val_rise, op_eq, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{mode_or,   5'd27, val_edge, op_ne, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0},
        '{mode_nor,  5'd29, val_low,  op_eq, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1},
        '{mode_nor,  5'd29, val_low,  op_eq, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{mode_or,   5'd31, val_high, op_eq, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1}
    };

    la_trigger_top #(.num_channels(num_channels)) i_dut (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .digital_in         (digital_in),
        .cfg_valid          (cfg_valid),
        .cfg_write          (cfg_write),
        .cfg_addr           (cfg_addr),
        .cfg_wdata          (cfg_wdata),
        .cfg_ready          (cfg_ready),
        .cfg_rdata          (cfg_rdata),
        .cfg_rvalid         (cfg_rvalid),
        .cfg_rready         (cfg_rready),
        .trig               (trig)
    );

    bind la_trigger_top la_trigger_asserts i_asserts (
        .clk                (clk),
        .analyzer_rstn_sync (analyzer_rstn_sync),
        .trig               (trig),
        .cfg_ready          (cfg_ready),
        .cfg_rvalid         (cfg_rvalid),
        .cfg_rready         (cfg_rready),
        .cfg_rdata          (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic chan_match(input logic [cond_width-1:0] cond, input logic p,
                                        input logic c);
        logic r;
        case (chan_value_e'(cond[2:0]))
            val_low:  r = !c;
            val_high: r = c;
            val_any:  r = 1'b1;
            val_rise: r = !p && c;
            val_fall: r = p && !c;
            val_edge: r = p != c;
            val_hold: r = p == c;
            default:  r = 1'b0;
        endcase
        return (cond[3] == op_ne) ? !r : r;
    endfunction

    function automatic logic mode_result(input trig_mode_e md, input logic [31:0] m);
        logic r;
        case (md)
            mode_and:  r = &m;
            mode_or:   r = |m;
            mode_nand: r = ~&m;
            default:   r = ~|m;  // nor
        endcase
        return r;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // called and returning at a falling edge
    task automatic write_reg(input logic [addr_width-1:0] addr, input logic [31:0] data);
        cfg_valid = 1'b1;
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        while (!cfg_ready) @(negedge clk);
        @(negedge clk);
        cfg_valid = 1'b0;
    endtask

    task automatic read_reg(input logic [addr_width-1:0] addr, input int hold,
                            output logic [31:0] data);
        logic [31:0] first;
        cfg_valid  = 1'b1;
        cfg_write  = 1'b0;
        cfg_addr   = addr;
        cfg_rready = (hold == 0);
        while (!cfg_ready) @(negedge clk);
        @(negedge clk);
        cfg_valid = 1'b0;
        cfg_addr  = ~addr;  // read mux now points at another register
        while (!cfg_rvalid) @(negedge clk);
        first = cfg_rdata;
        repeat (hold) begin
            @(negedge clk);
            checks++;
            assert (cfg_rvalid && !cfg_ready && cfg_rdata === first) else begin
                errors++;
                $display("Error at %0t: held read response changed, rvalid %b ready %b rdata %h",
                         $time, cfg_rvalid, cfg_ready, cfg_rdata);
            end
        end
        cfg_rready = 1'b1;
        @(negedge clk);  // response taken at the edge before
        data = first;
    endtask

    initial begin
        row_t                  r;
        int                    cls_cur;
        int                    cls_new;
        int                    last_target;
        logic [cond_width-1:0] cls_cond;
        logic [31:0]           base;
        logic [31:0]           lvl_prev;
        logic [31:0]           lvl_cur;
        logic [31:0]           m;
        logic [31:0]           rd;
        logic                  exp;

        analyzer_rstn_sync = 1'b0;
        digital_in = '0;
        cfg_valid  = 1'b0;
        cfg_write  = 1'b0;
        cfg_addr   = '0;
        cfg_wdata  = '0;
        cfg_rready = 1'b1;
        errors = 0;
        checks = 0;
        lfsr   = 16'd49;
        for (int i = 0; i < num_channels; i++) begin
            cond_model[i] = cond_reset;
        end
        repeat (5) @(negedge clk);
        analyzer_rstn_sync = 1'b1;
        @(negedge clk);

        read_reg(addr_cond_base + 8'd5, 0, rd);
        check_value("reset condition", rd, 32'(cond_reset));
        write_reg(addr_mode, 32'h3);
        read_reg(addr_mode, 0, rd);
        check_value("mode readback", rd, 32'h3);
        write_reg(addr_mode, 32'h0);
        write_reg(addr_cond_base + 8'd6, 32'hc);
        read_reg(addr_cond_base + 8'd6, 4, rd);  // response held off for 4 cycles
        check_value("condition readback", rd, 32'hc);
        write_reg(addr_cond_base + 8'd6, 32'(cond_reset));
        write_reg(addr_ctrl, 32'h100);
        read_reg(addr_ctrl, 0, rd);
        check_value("control with force bit", rd, 32'h0);
        read_reg(8'h05, 0, rd);
        check_value("unmapped address 0x05", rd, rdata_unmapped);
        read_reg(8'h30, 0, rd);
        check_value("unmapped address 0x30", rd, rdata_unmapped);

        cls_cur = 0;
        last_target = 0;
        for (int n = 0; n < num_rows; n++) begin
            r = rows[n];
            // or/nor need the other channels false, and/nand need them true
            cls_new  = (r.mode == mode_or || r.mode == mode_nor) ? 1 : 0;
            cls_cond = (cls_new == 1) ? {op_ne, val_hold} : cond_reset;
            write_reg(addr_ctrl, 32'h0);  // disarm while reconfiguring
            write_reg(addr_mode, {30'b0, r.mode});
            if (cls_new != cls_cur) begin
                for (int i = 0; i < num_channels; i++) begin
                    write_reg(addr_cond_base + 8'(i), 32'(cls_cond));
                    cond_model[i] = cls_cond;
                end
                cls_cur = cls_new;
            end else if (last_target != int'(r.chan)) begin
                write_reg(addr_cond_base + 8'(last_target), 32'(cls_cond));
                cond_model[last_target] = cls_cond;
            end
            write_reg(addr_cond_base + 8'(r.chan), {28'b0, r.op, r.code});
            cond_model[r.chan] = {r.op, r.code};
            last_target = int'(r.chan);

            for (int i = 0; i < num_channels; i++) begin
                lfsr = lfsr_next(lfsr);
                base[i] = lfsr[0];
            end
            lvl_prev = base;
            lvl_prev[r.chan] = r.lvl_prev;
            lvl_cur = base;
            lvl_cur[r.chan] = r.lvl_cur;
            digital_in = lvl_prev;
            repeat (2) @(negedge clk);  // fill both sample stages
            digital_in = lvl_cur;       // sampling edge follows
            @(negedge clk);
            // arm lands one edge after sampling so only this sample pair counts
            write_reg(addr_ctrl, {23'b0, r.force_on, 7'b0, r.arm_on});
            check_value("trig one cycle after sampling", {31'b0, trig}, 32'h0);
            @(negedge clk);

            for (int i = 0; i < num_channels; i++) begin
                m[i] = chan_match(cond_model[i], lvl_prev[i], lvl_cur[i]);
            end
            exp = r.arm_on & (r.force_on | mode_result(r.mode, m));
            assert (exp == r.exp_trig) else begin
                errors++;
                $display("Error at %0t: row %0d lists trig %b but the rules give %b",
                         $time, n, r.exp_trig, exp);
            end
            check_value($sformatf("row %0d trig", n), {31'b0, trig}, {31'b0, exp});
            @(negedge clk);
            read_reg(addr_ctrl, 0, rd);
            check_value($sformatf("row %0d arm", n), rd, {31'b0, r.arm_on & ~exp});
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

/* all.f */
logic/la_pkg.sv
logic/la_cfg_regs.sv
logic/la_channel_match.sv
logic/la_trigger_combine.sv
logic/la_trigger_top.sv
verif/la_trigger_asserts.sv
verif/la_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module la_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vla_tb 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
